// ==== fm_regs_top.f ====
+incdir+.
logic/fm_pkg.sv
logic/fm_ring.sv
logic/fm_mmr.sv
logic/fm_slot_regs.sv
logic/fm_timers.sv
logic/fm_regs_top.sv
tests/fm_regs_props.sv
tests/fm_regs_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= fm_regs_tb
RTL_TOP   ?= fm_regs_top
FLIST     ?= fm_regs_top.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/fm_regs_tb.sv ====
/*
 * FM register front end testbench
 * Applies a table of host writes, compares every slot against a
 * reference model over a full rotation, then exercises both timers
 */

`timescale 1ns/1ns
`default_nettype none

`include "fm_cfg.svh"

module fm_regs_tb import fm_pkg::*; ();

	localparam int NUM = 20;
	localparam int LIMIT = NUM * 60 + 16 * `FM_TB_DIV + 200;

	// Table columns are register, part, fixed data, random data flag and slot to wait for
	localparam logic [7:0] TBL_REG [NUM] = '{
		8'h34, 8'h38, 8'h44, 8'h5C, 8'h31, 8'h46, 8'h52, 8'h33, 8'hA5, 8'hA1,
		8'hB1, 8'hA6, 8'hA2, 8'hB2, 8'h28, 8'h28, 8'h28, 8'h28, 8'h22, 8'h2A};
	localparam logic TBL_PART [NUM] = '{
		0, 0, 0, 0, 1, 1, 1, 0, 0, 0, 0, 1, 1, 1, 0, 1, 0, 0, 0, 0};
	localparam logic [7:0] TBL_DATA [NUM] = '{
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00, 8'h00, 8'hB1, 8'h56, 8'h03, 8'hE1, 8'h00, 8'h00};
	localparam logic TBL_RND [NUM] = '{
		1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 1, 1};
	localparam logic [4:0] TBL_SLOT [NUM] = '{
		5'd1, 5'd2, 5'd1, 5'd3, 5'd16, 5'd21, 5'd20, 5'd0, 5'd4, 5'd4,
		5'd4, 5'd20, 5'd20, 5'd20, 5'd4, 5'd20, 5'd0, 5'd4, 5'd0, 5'd0};

	logic       clk;
	logic       rst;
	logic [7:0] din;
	logic       write;
	logic [1:0] addr;
	logic       busy;
	logic [4:0] cur_slot;
	op_params_t cur_op;
	ch_params_t cur_ch;
	logic       lfo_en;
	logic [2:0] lfo_freq;
	logic [8:0] pcm;
	logic       flag_a;
	logic       flag_b;
	logic       irq;

	// Reference model state
	op_params_t op_sh [`FM_SLOTS];
	ch_params_t ch_sh [`FM_CHANNELS];
	logic [5:0] latch_sh;
	logic [3:0] lfo_sh;
	logic [8:0] pcm_sh;
	logic [15:0] lfsr;
	int         cycles;

	fm_regs_top fm_regs_top_inst (
		.clk      (clk),
		.rst      (rst),
		.din      (din),
		.write    (write),
		.addr     (addr),
		.busy     (busy),
		.cur_slot (cur_slot),
		.cur_op   (cur_op),
		.cur_ch   (cur_ch),
		.lfo_en   (lfo_en),
		.lfo_freq (lfo_freq),
		.pcm      (pcm),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.irq      (irq)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout: the DUT did not finish within %0d cycles", LIMIT);
			$display("Verification failed");
			$fatal(1, "run stopped on timeout");
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// One host write, then wait for busy to drop
	task automatic host_write(input logic is_data, input logic part, input logic [7:0] d);
		write = 1'b1;
		addr = {part, is_data};
		din = d;
		@(negedge clk);
		write = 1'b0;
		compare("busy after accepted write", 32'(busy), 32'h1);
		while (busy)
			@(negedge clk);
	endtask

	task automatic model_write(input logic [7:0] r, input logic part, input logic [7:0] d);
		int ch;
		int slot;
		int kc;
		ch = r[1:0] + (part ? 3 : 0);
		slot = ch * 4 + r[3:2];
		kc = d[1:0] + (d[2] ? 3 : 0);
		if (r == 8'h28 && d[1:0] != 2'b11) begin
			for (int i = 0; i < 4; i++)
				op_sh[kc * 4 + i].kon = d[4 + i];
		end else if (r == 8'h22) begin
			lfo_sh = d[3:0];
		end else if (r == 8'h2A) begin
			pcm_sh = {d, 1'b0};
		end else if (r[1:0] != 2'b11) begin
			case (r[7:4])
				4'h3: {op_sh[slot].dt1, op_sh[slot].mul} = {d[6:4], d[3:0]};
				4'h4: op_sh[slot].tl = d[6:0];
				4'h5: {op_sh[slot].ks, op_sh[slot].ar} = {d[7:6], d[4:0]};
				4'hA: begin
					if (r[2])
						latch_sh = d[5:0];
					else
						{ch_sh[ch].block, ch_sh[ch].fnum} = {latch_sh[5:3], latch_sh[2:0], d};
				end
				4'hB: {ch_sh[ch].fb, ch_sh[ch].alg} = {d[5:3], d[2:0]};
				default: ;
			endcase
		end
	endtask

	// Wait for the target slot, then check one whole rotation
	task automatic verify_rotation(input logic [4:0] target);
		int slot;
		while (cur_slot != target)
			@(negedge clk);
		slot = target;
		repeat (`FM_SLOTS) begin
			compare("slot sequence", 32'(cur_slot), 32'(slot));
			compare($sformatf("operator slot %0d", slot), 32'(cur_op), 32'(op_sh[slot]));
			compare($sformatf("channel of slot %0d", slot), 32'(cur_ch),
				32'(ch_sh[slot / 4]));
			compare("lfo", 32'({lfo_en, lfo_freq}), 32'(lfo_sh));
			compare("pcm", 32'(pcm), 32'(pcm_sh));
			slot = (slot + 1) % `FM_SLOTS;
			@(negedge clk);
		end
	endtask

	task automatic wait_timer(input logic use_b, input int bound);
		int n;
		n = 0;
		while (!((use_b ? flag_b : flag_a) && irq) && n < bound) begin
			@(negedge clk);
			n++;
		end
		compare(use_b ? "timer B flag and irq" : "timer A flag and irq",
			32'({use_b ? flag_b : flag_a, irq}), 32'h3);
	endtask

	initial begin
		logic [7:0] d;
		logic [7:0] first;
		clk = 1'b0;
		rst = 1'b1;
		din = 8'h00;
		write = 1'b0;
		addr = 2'b00;
		cycles = 0;
		lfsr = 16'd36412;
		latch_sh = '0;
		lfo_sh = '0;
		pcm_sh = '0;
		for (int i = 0; i < `FM_SLOTS; i++)
			op_sh[i] = '0;
		for (int i = 0; i < `FM_CHANNELS; i++)
			ch_sh[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int e = 0; e < NUM; e++) begin
			if (TBL_RND[e])
				rand_byte(d);
			else
				d = TBL_DATA[e];
			host_write(1'b0, TBL_PART[e], TBL_REG[e]);
			host_write(1'b1, TBL_PART[e], d);
			model_write(TBL_REG[e], TBL_PART[e], d);
			verify_rotation(TBL_SLOT[e]);
		end

		// Second data write lands while busy is still high
		rand_byte(first);
		host_write(1'b0, 1'b0, REG_PCM);
		write = 1'b1;
		addr = 2'b01;
		din = first;
		@(negedge clk);
		din = ~first;
		@(negedge clk);
		write = 1'b0;
		while (busy)
			@(negedge clk);
		model_write(REG_PCM, 1'b0, first);
		compare("pcm after write during busy", 32'(pcm), 32'(pcm_sh));

		// Timer A preload 1020
		host_write(1'b0, 1'b0, REG_CLKA1);
		host_write(1'b1, 1'b0, 8'd255);
		host_write(1'b0, 1'b0, REG_CLKA2);
		host_write(1'b1, 1'b0, 8'd0);
		host_write(1'b0, 1'b0, REG_TIMER);
		host_write(1'b1, 1'b0, 8'h05);
		wait_timer(1'b0, 8);
		host_write(1'b1, 1'b0, 8'h10);
		@(negedge clk);
		compare("timer A cleared", 32'({flag_a, irq}), 32'h0);

		// Timer B preload near overflow
		host_write(1'b0, 1'b0, REG_CLKB);
		host_write(1'b1, 1'b0, 8'hFE);
		host_write(1'b0, 1'b0, REG_TIMER);
		host_write(1'b1, 1'b0, 8'h0A);
		wait_timer(1'b1, 8 * `FM_TB_DIV);
		host_write(1'b1, 1'b0, 8'h20);
		@(negedge clk);
		compare("timer B cleared", 32'({flag_b, irq}), 32'h0);

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/fm_regs_props.sv ====
/*
 * FM register front end properties
 * Busy after reset, interrupt tracking, slot rotation and pending
 */

`timescale 1ns/1ns
`default_nettype none

`include "fm_cfg.svh"

module fm_regs_props (
	input wire       clk,
	input wire       rst,
	input wire       busy,
	input wire       flag_a,
	input wire       flag_b,
	input wire       irq,
	input wire [4:0] cur_slot,
	input wire       upd,
	input wire       pending
);

	busy_reset: assert property (@(posedge clk) rst |=> !busy)
		else $error("busy high after reset");

	irq_follow: assert property (@(posedge clk) disable iff (rst)
		(flag_a || flag_b) |=> irq)
		else $error("irq missed a flag");

	irq_quiet: assert property (@(posedge clk) disable iff (rst)
		!(flag_a || flag_b) |=> !irq)
		else $error("irq without a flag");

	slot_step: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> int'(cur_slot) == (int'($past(cur_slot)) + 1) % `FM_SLOTS)
		else $error("slot counter skipped");

	pending_cause: assert property (@(posedge clk) disable iff (rst)
		$rose(pending) |-> $past(upd))
		else $error("pending rose without an update");

endmodule

bind fm_regs_top fm_regs_props props_inst (
	.clk      (clk),
	.rst      (rst),
	.busy     (busy),
	.flag_a   (flag_a),
	.flag_b   (flag_b),
	.irq      (irq),
	.cur_slot (cur_slot),
	.upd      (upd),
	.pending  (pending)
);

`default_nettype wire

// ==== logic/fm_regs_top.sv ====
/*
 * FM register front end
 * Host write decoder, time-multiplexed parameter store and timers
 */

`timescale 1ns/1ns
`default_nettype none

`include "fm_cfg.svh"

module fm_regs_top import fm_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire  [7:0] din,
	input  wire        write,
	input  wire  [1:0] addr,
	output logic       busy,
	output logic [4:0] cur_slot,
	output op_params_t cur_op,
	output ch_params_t cur_ch,
	output logic       lfo_en,
	output logic [2:0] lfo_freq,
	output logic [8:0] pcm,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq
);

	logic                   upd;
	upd_kind_t              upd_kind;
	logic [4:0]             upd_slot;
	logic [7:0]             upd_data;
	logic                   pending;
	logic [`FM_TA_BITS-1:0] value_a;
	logic [`FM_TB_BITS-1:0] value_b;
	logic                   load_a;
	logic                   load_b;
	logic                   clr_flag_a;
	logic                   clr_flag_b;
	logic                   irq_en_a;
	logic                   irq_en_b;

	fm_mmr mmr_inst (
		.clk        (clk),
		.rst        (rst),
		.din        (din),
		.write      (write),
		.addr       (addr),
		.pending    (pending),
		.busy       (busy),
		.upd        (upd),
		.upd_kind   (upd_kind),
		.upd_slot   (upd_slot),
		.upd_data   (upd_data),
		.value_a    (value_a),
		.value_b    (value_b),
		.load_a     (load_a),
		.load_b     (load_b),
		.clr_flag_a (clr_flag_a),
		.clr_flag_b (clr_flag_b),
		.irq_en_a   (irq_en_a),
		.irq_en_b   (irq_en_b),
		.lfo_en     (lfo_en),
		.lfo_freq   (lfo_freq),
		.pcm        (pcm)
	);

	fm_slot_regs slot_regs_inst (
		.clk      (clk),
		.rst      (rst),
		.upd      (upd),
		.upd_kind (upd_kind),
		.upd_slot (upd_slot),
		.upd_data (upd_data),
		.pending  (pending),
		.cur_slot (cur_slot),
		.cur_op   (cur_op),
		.cur_ch   (cur_ch)
	);

	fm_timers timers_inst (
		.clk        (clk),
		.rst        (rst),
		.value_a    (value_a),
		.value_b    (value_b),
		.load_a     (load_a),
		.load_b     (load_b),
		.clr_flag_a (clr_flag_a),
		.clr_flag_b (clr_flag_b),
		.irq_en_a   (irq_en_a),
		.irq_en_b   (irq_en_b),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.irq        (irq)
	);

endmodule

`default_nettype wire

// ==== logic/fm_timers.sv ====
/*
 * FM interval timers
 * Reloading timer A and prescaled timer B with sticky
 * overflow flags and a registered interrupt
 */

`timescale 1ns/1ns
`default_nettype none

`include "fm_cfg.svh"

module fm_timers (
	input  wire                   clk,
	input  wire                   rst,
	input  wire [`FM_TA_BITS-1:0] value_a,
	input  wire [`FM_TB_BITS-1:0] value_b,
	input  wire                   load_a,
	input  wire                   load_b,
	input  wire                   clr_flag_a,
	input  wire                   clr_flag_b,
	input  wire                   irq_en_a,
	input  wire                   irq_en_b,
	output logic                  flag_a,
	output logic                  flag_b,
	output logic                  irq
);

	localparam int DIV_BITS = $clog2(`FM_TB_DIV);

	logic [`FM_TA_BITS-1:0] cnt_a;
	logic [`FM_TB_BITS-1:0] cnt_b;
	logic [DIV_BITS-1:0]    div_cnt;
	logic                   tick_b;
	logic                   ovf_a;
	logic                   ovf_b;

	assign tick_b = div_cnt == DIV_BITS'(`FM_TB_DIV - 1);
	assign ovf_a = &cnt_a && !load_a;
	assign ovf_b = &cnt_b && tick_b && !load_b;

	// Timer A counts every clock
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_a <= '0;
			flag_a <= 1'b0;
		end else begin
			if (load_a || ovf_a)
				cnt_a <= value_a;
			else
				cnt_a <= cnt_a + 1'b1;
			if (clr_flag_a)
				flag_a <= 1'b0;
			else if (ovf_a && irq_en_a)
				flag_a <= 1'b1;
		end
	end

	// Timer B counts on prescaler ticks only
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			cnt_b <= '0;
			flag_b <= 1'b0;
		end else begin
			div_cnt <= tick_b ? '0 : div_cnt + 1'b1;
			if (load_b || ovf_b)
				cnt_b <= value_b;
			else if (tick_b)
				cnt_b <= cnt_b + 1'b1;
			if (clr_flag_b)
				flag_b <= 1'b0;
			else if (ovf_b && irq_en_b)
				flag_b <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			irq <= 1'b0;
		else
			irq <= flag_a || flag_b;
	end

endmodule

`default_nettype wire

// ==== logic/fm_slot_regs.sv ====
/*
 * Slot sequencer and parameter store
 * Rotates the operator and channel rings and applies a pending
 * update when its target slot reaches the head
 */

`timescale 1ns/1ns
`default_nettype none

`include "fm_cfg.svh"

module fm_slot_regs import fm_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        upd,
	input  var  upd_kind_t upd_kind,
	input  wire [4:0]  upd_slot,
	input  wire [7:0]  upd_data,
	output logic       pending,
	output logic [4:0] cur_slot,
	output op_params_t cur_op,
	output ch_params_t cur_ch
);

	upd_kind_t  pend_kind;
	logic [4:0] pend_slot;
	logic [7:0] pend_data;
	logic [5:0] block_latch;
	logic       kon_run;
	logic       slot_hit;
	logic       ch_hit;
	logic       op_wr;
	logic       kon_wr;
	logic       ch_wr;
	logic       done;
	op_params_t op_new;
	ch_params_t ch_new;

	assign slot_hit = pending && cur_slot == pend_slot;
	assign ch_hit = pending && cur_slot[4:2] == pend_slot[4:2];

	assign op_wr = slot_hit && pend_kind inside {UPD_DT1_MUL, UPD_TL, UPD_KS_AR};
	assign ch_wr = slot_hit && pend_kind inside {UPD_FNUM, UPD_FB_ALG};
	// Key-on walks all four operators starting from operator 0
	assign kon_wr = ch_hit && pend_kind == UPD_KON && (kon_run || cur_slot[1:0] == 2'd0);
	assign done = op_wr || ch_wr || (kon_wr && cur_slot[1:0] == 2'd3);

	always_comb begin
		op_new = cur_op;
		case (pend_kind)
			UPD_DT1_MUL: begin
				op_new.dt1 = pend_data[6:4];
				op_new.mul = pend_data[3:0];
			end
			UPD_TL: op_new.tl = pend_data[6:0];
			UPD_KS_AR: begin
				op_new.ks = pend_data[7:6];
				op_new.ar = pend_data[4:0];
			end
			// Key bits 7:4 map to operators 3:0
			UPD_KON: op_new.kon = pend_data[{1'b1, cur_slot[1:0]}];
			default: ;
		endcase
	end

	always_comb begin
		ch_new = cur_ch;
		if (pend_kind == UPD_FNUM) begin
			ch_new.fnum = {block_latch[2:0], pend_data};
			ch_new.block = block_latch[5:3];
		end else begin
			ch_new.fb = pend_data[5:3];
			ch_new.alg = pend_data[2:0];
		end
	end

	always_ff @(posedge clk) begin
		if (upd && upd_kind != UPD_BLOCK_LATCH) begin
			pend_kind <= upd_kind;
			pend_slot <= upd_slot;
			pend_data <= upd_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_slot <= 5'd0;
			pending <= 1'b0;
			kon_run <= 1'b0;
			block_latch <= 6'd0;
		end else begin
			cur_slot <= (cur_slot == 5'(`FM_SLOTS - 1)) ? 5'd0 : cur_slot + 5'd1;
			kon_run <= kon_wr && cur_slot[1:0] != 2'd3;
			// High fnum byte waits here for the 0xA0 write
			if (upd && upd_kind == UPD_BLOCK_LATCH)
				block_latch <= upd_data[5:0];
			if (upd && upd_kind != UPD_BLOCK_LATCH)
				pending <= 1'b1;
			else if (done)
				pending <= 1'b0;
		end
	end

	fm_ring #(
		.T     (op_params_t),
		.DEPTH (`FM_SLOTS)
	) op_ring (
		.clk     (clk),
		.rst     (rst),
		.advance (1'b1),
		.wr      (op_wr || kon_wr),
		.wr_data (op_new),
		.head    (cur_op)
	);

	// Channel ring moves on after the last operator of a channel
	fm_ring #(
		.T     (ch_params_t),
		.DEPTH (`FM_CHANNELS)
	) ch_ring (
		.clk     (clk),
		.rst     (rst),
		.advance (cur_slot[1:0] == 2'd3),
		.wr      (ch_wr),
		.wr_data (ch_new),
		.head    (cur_ch)
	);

endmodule

`default_nettype wire

// ==== logic/fm_mmr.sv ====
/*
 * FM host write decoder
 * Holds the global registers and turns slot register writes
 * into update strobes toward the slot store
 */

`timescale 1ns/1ns
`default_nettype none

`include "fm_cfg.svh"

module fm_mmr import fm_pkg::*; (
	input  wire                    clk,
	input  wire                    rst,
	input  wire  [7:0]             din,
	input  wire                    write,
	input  wire  [1:0]             addr,
	input  wire                    pending,
	output logic                   busy,
	output logic                   upd,
	output upd_kind_t              upd_kind,
	output logic [4:0]             upd_slot,
	output logic [7:0]             upd_data,
	output logic [`FM_TA_BITS-1:0] value_a,
	output logic [`FM_TB_BITS-1:0] value_b,
	output logic                   load_a,
	output logic                   load_b,
	output logic                   clr_flag_a,
	output logic                   clr_flag_b,
	output logic                   irq_en_a,
	output logic                   irq_en_b,
	output logic                   lfo_en,
	output logic [2:0]             lfo_freq,
	output logic [8:0]             pcm
);

	logic [7:0] sel_reg;
	logic [2:0] up_ch;
	logic [1:0] up_op;
	logic       ch_ok;
	logic       accept;
	logic [2:0] kon_ch;
	logic       op_kind;
	logic       slot_valid;
	upd_kind_t  slot_kind;
	logic       nxt_upd;
	upd_kind_t  nxt_kind;
	logic [4:0] nxt_slot;

	assign accept = write && !busy;

	// Key-on channel code 0-2 for part 0 and 4-6 for part 1
	assign kon_ch = {1'b0, din[1:0]} + (din[2] ? 3'd3 : 3'd0);

	// Decode the selected register into an update kind
	always_comb begin
		op_kind = 1'b1;
		slot_valid = 1'b1;
		slot_kind = UPD_DT1_MUL;
		case ({sel_reg[7:4], 4'h0})
			REG_DT1_MUL: slot_kind = UPD_DT1_MUL;
			REG_TL:      slot_kind = UPD_TL;
			REG_KS_AR:   slot_kind = UPD_KS_AR;
			default: begin
				op_kind = 1'b0;
				case ({sel_reg[7:2], 2'b00})
					REG_FNUM_LO: slot_kind = UPD_FNUM;
					REG_FNUM_HI: slot_kind = UPD_BLOCK_LATCH;
					REG_FB_ALG:  slot_kind = UPD_FB_ALG;
					default:     slot_valid = 1'b0;
				endcase
			end
		endcase
	end

	always_comb begin
		nxt_upd = 1'b0;
		nxt_kind = slot_kind;
		nxt_slot = op_kind ? {up_ch, up_op} : {up_ch, 2'b00};
		if (accept && addr[0]) begin
			if (sel_reg == REG_KON) begin
				nxt_upd = din[1:0] != 2'b11;
				nxt_kind = UPD_KON;
				nxt_slot = {kon_ch, 2'b00};
			end else if (sel_reg >= REG_DT1_MUL) begin
				nxt_upd = slot_valid && ch_ok;
			end
		end
	end

	// Update payload travels alongside the strobe
	always_ff @(posedge clk) begin
		if (nxt_upd) begin
			upd_kind <= nxt_kind;
			upd_slot <= nxt_slot;
			upd_data <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			upd <= 1'b0;
			sel_reg <= 8'h00;
			up_ch <= 3'd0;
			up_op <= 2'd0;
			ch_ok <= 1'b0;
			value_a <= '0;
			value_b <= '0;
			{load_a, load_b, clr_flag_a, clr_flag_b} <= 4'b0000;
			{irq_en_a, irq_en_b} <= 2'b00;
			lfo_en <= 1'b0;
			lfo_freq <= 3'd0;
			pcm <= 9'd0;
		end else begin
			// Single-cycle pulses
			upd <= nxt_upd;
			{load_a, load_b, clr_flag_a, clr_flag_b} <= 4'b0000;

			// Slot writes keep busy up until the ring takes them
			if (accept)
				busy <= 1'b1;
			else
				busy <= busy && (upd || pending);

			if (accept && !addr[0]) begin
				sel_reg <= din;
				up_ch <= {1'b0, din[1:0]} + (addr[1] ? 3'd3 : 3'd0);
				up_op <= din[3:2];
				ch_ok <= din[1:0] != 2'b11;
			end else if (accept) begin
				case (sel_reg)
					REG_LFO:   {lfo_en, lfo_freq} <= din[3:0];
					REG_CLKA1: value_a[`FM_TA_BITS-1:2] <= din;
					REG_CLKA2: value_a[1:0] <= din[1:0];
					REG_CLKB:  value_b <= din;
					REG_TIMER: begin
						load_a <= din[0];
						load_b <= din[1];
						irq_en_a <= din[2];
						irq_en_b <= din[3];
						clr_flag_a <= din[4];
						clr_flag_b <= din[5];
					end
					// 8-bit sample left aligned in the 9-bit DAC word
					REG_PCM:   pcm <= {din, 1'b0};
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/fm_ring.sv ====
/*
 * Rotating parameter ring
 * Shifts one entry per advance; the head entry may be
 * rewritten as it passes
 */

`timescale 1ns/1ns
`default_nettype none

module fm_ring #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input  wire clk,
	input  wire rst,
	input  wire advance,
	input  wire wr,
	input  var  T wr_data,
	output T    head
);

	T mem [DEPTH];

	assign head = mem[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end else if (advance) begin
			for (int i = 0; i < DEPTH - 1; i++)
				mem[i] <= mem[i + 1];
			// Head goes around to the tail and is replaced on a write
			mem[DEPTH - 1] <= wr ? wr_data : mem[0];
		end else if (wr) begin
			mem[0] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/fm_pkg.sv ====
/*
 * FM register front end types
 * Operator and channel parameter records, register map, update kinds
 */

`default_nettype none

package fm_pkg;

	// Per-operator parameters, one ring entry per slot
	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       kon;
	} op_params_t;

	// Per-channel parameters
	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [1:0]  rl;
	} ch_params_t;

	// Global registers
	localparam logic [7:0] REG_LFO   = 8'h22;
	localparam logic [7:0] REG_CLKA1 = 8'h24;
	localparam logic [7:0] REG_CLKA2 = 8'h25;
	localparam logic [7:0] REG_CLKB  = 8'h26;
	localparam logic [7:0] REG_TIMER = 8'h27;
	localparam logic [7:0] REG_KON   = 8'h28;
	localparam logic [7:0] REG_PCM   = 8'h2A;

	// Operator group bases of 16 addresses each
	localparam logic [7:0] REG_DT1_MUL = 8'h30;
	localparam logic [7:0] REG_TL      = 8'h40;
	localparam logic [7:0] REG_KS_AR   = 8'h50;

	// Channel registers of 4 addresses each
	localparam logic [7:0] REG_FNUM_LO = 8'hA0;
	localparam logic [7:0] REG_FNUM_HI = 8'hA4;
	localparam logic [7:0] REG_FB_ALG  = 8'hB0;

	typedef enum logic [2:0] {
		UPD_DT1_MUL,
		UPD_TL,
		UPD_KS_AR,
		UPD_KON,
		UPD_FNUM,
		UPD_BLOCK_LATCH,
		UPD_FB_ALG
	} upd_kind_t;

endpackage

`default_nettype wire

// ==== fm_cfg.svh ====
/*
 * FM register front end configuration
 * Slot rotation length, channel count and timer sizing
 */

`ifndef FM_CFG_SVH
`define FM_CFG_SVH

// Operator slots in one rotation with four per channel
`define FM_SLOTS 24

// Channels across both parts
`define FM_CHANNELS 6

// Timer A interval counter width
`define FM_TA_BITS 10

// Timer B interval counter width
`define FM_TB_BITS 8

// Timer B steps once every FM_TB_DIV clocks
`define FM_TB_DIV 16

`endif
